// ==== design/ddr4_cmd_pkg.sv ====
package ddr4_cmd_pkg;

    // DRAM address geometry
    localparam int COL_BITS = 4;  // Column within a row
    localparam int BA_BITS = 2;   // Bank within a bank group
    localparam int BG_BITS = 2;   // Bank group
    localparam int ROW_BITS = 8;  // Row within a bank

    localparam int NUM_BANKS = 2 ** (BG_BITS + BA_BITS);  // 16 banks over all groups

    // Flat host address, low to high: column, bank, bank group, row
    localparam int HOST_ADDR_BITS = COL_BITS + BA_BITS + BG_BITS + ROW_BITS;

    localparam int DRAM_ADDR_BITS = 17;  // A16..A0 on the DDR4 pins

    // Commands the scheduler can choose
    typedef enum logic [2:0] {
        NOP           = 3'd0,
        READ          = 3'd1,
        WRITE         = 3'd2,
        ACTIVATE      = 3'd3,
        PRECHARGE     = 3'd4,
        PRECHARGE_ALL = 3'd5,
        REFRESH       = 3'd6
    } dram_cmd_e;

    // Host request after the address split
    typedef struct packed {
        logic                write;  // High for a write access
        logic [BG_BITS-1:0]  bg;
        logic [BA_BITS-1:0]  ba;
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
    } dram_req_t;

    // Command picked by the scheduler, before pin encoding
    typedef struct packed {
        dram_cmd_e           cmd;
        logic [BG_BITS-1:0]  bg;
        logic [BA_BITS-1:0]  ba;
        logic [ROW_BITS-1:0] row;
        logic [COL_BITS-1:0] col;
    } dram_sel_t;

    // DDR4 command/address pins, strobes active low
    typedef struct packed {
        logic                      cs_n;
        logic                      act_n;
        logic                      ras_n;  // Doubles as A16 during ACTIVATE
        logic                      cas_n;  // Doubles as A15
        logic                      we_n;   // Doubles as A14
        logic [BG_BITS-1:0]        bg;
        logic [BA_BITS-1:0]        ba;
        logic [DRAM_ADDR_BITS-1:0] addr;
    } dram_pins_t;

endpackage : ddr4_cmd_pkg

// ==== design/ddr4_req_queue.sv ====
`timescale 1ns/1ps

module ddr4_req_queue #(
    parameter int QUEUE_DEPTH = 8
) (
    input  logic                                    clk_in,
    input  logic                                    rst_in,
    input  logic                                    req_valid,
    input  logic                                    req_write,
    input  logic [ddr4_cmd_pkg::HOST_ADDR_BITS-1:0] req_addr,
    input  logic                                    pop,         // Head request fully issued
    output logic                                    req_ready,
    output logic                                    head_valid,
    output ddr4_cmd_pkg::dram_req_t                 head
);
    import ddr4_cmd_pkg::*;

    localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    dram_req_t mem [QUEUE_DEPTH];  // Entry storage
    dram_req_t enq_req;             // Incoming request, decoded

    logic [PTR_BITS-1:0] head_ptr;
    logic [PTR_BITS-1:0] tail_ptr;
    logic [PTR_BITS:0]   count;     // Entries held, 0..QUEUE_DEPTH
    logic [PTR_BITS:0]   tail_sum;  // head_ptr + count before wrap
    logic                enq;
    logic                deq;

    // Address split, column at the bottom
    always_comb begin
        enq_req.write = req_write;
        enq_req.col = req_addr[COL_BITS-1:0];
        enq_req.ba = req_addr[COL_BITS +: BA_BITS];
        enq_req.bg = req_addr[COL_BITS+BA_BITS +: BG_BITS];
        enq_req.row = req_addr[COL_BITS+BA_BITS+BG_BITS +: ROW_BITS];
    end

    assign req_ready = (count != (PTR_BITS+1)'(QUEUE_DEPTH));  // Not full
    assign head_valid = (count != '0);                        // Not empty
    assign enq = req_valid && req_ready;
    assign deq = pop && head_valid;

    // Tail slot wraps around the buffer end
    assign tail_sum = {1'b0, head_ptr} + count;
    assign tail_ptr = (tail_sum >= (PTR_BITS+1)'(QUEUE_DEPTH)) ?
        PTR_BITS'(tail_sum - (PTR_BITS+1)'(QUEUE_DEPTH)) : PTR_BITS'(tail_sum);

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            head_ptr <= '0;
            count <= '0;
        end else begin
            if (deq) begin
                head_ptr <= (head_ptr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : head_ptr + 1'b1;
            end
            case ({enq, deq})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;  // Both or neither, size holds
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (enq) begin
            mem[tail_ptr] <= enq_req;
        end
    end

    assign head = mem[head_ptr];

endmodule : ddr4_req_queue

// ==== design/ddr4_bank_tracker.sv ====
`timescale 1ns/1ps

module ddr4_bank_tracker (
    input  logic                                                    clk_in,
    input  logic                                                    rst_in,
    input  logic                                                    issue_valid,
    input  ddr4_cmd_pkg::dram_sel_t                                 issued,
    output logic [ddr4_cmd_pkg::NUM_BANKS-1:0]                      open_banks,
    output logic [ddr4_cmd_pkg::NUM_BANKS-1:0][ddr4_cmd_pkg::ROW_BITS-1:0] open_rows
);
    import ddr4_cmd_pkg::*;

    logic [BG_BITS+BA_BITS-1:0] bank_idx;  // Flat bank number {bg, ba}
    logic [NUM_BANKS-1:0]       open_q;
    logic [NUM_BANKS-1:0][ROW_BITS-1:0] row_q;

    assign bank_idx = {issued.bg, issued.ba};

    // Open flag per bank
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            open_q <= '0;  // All banks precharged
        end else if (issue_valid) begin
            case (issued.cmd)
                ACTIVATE: open_q[bank_idx] <= 1'b1;
                PRECHARGE: open_q[bank_idx] <= 1'b0;
                PRECHARGE_ALL: open_q <= '0;
                default: open_q <= open_q;  // Accesses and refresh leave banks as they are
            endcase
        end
    end

    // Row held in each bank's sense amps, only meaningful while open
    always_ff @(posedge clk_in) begin
        if (issue_valid && issued.cmd == ACTIVATE) begin
            row_q[bank_idx] <= issued.row;
        end
    end

    assign open_banks = open_q;
    assign open_rows = row_q;

endmodule : ddr4_bank_tracker

// ==== design/ddr4_cmd_scheduler.sv ====
`timescale 1ns/1ps

module ddr4_cmd_scheduler #(
    parameter int PRECHARGE_LATENCY  = 5,    // tRP
    parameter int ACTIVATION_LATENCY = 8,    // tRCD
    parameter int ACCESS_LATENCY     = 4,    // Spacing after a read or write
    parameter int REFRESH_LATENCY    = 12,   // tRFC
    parameter int REFRESH_INTERVAL   = 200
) (
    input  logic                                                    clk_in,
    input  logic                                                    rst_in,
    input  logic                                                    head_valid,
    input  ddr4_cmd_pkg::dram_req_t                                 head,
    input  logic [ddr4_cmd_pkg::NUM_BANKS-1:0]                      open_banks,
    input  logic [ddr4_cmd_pkg::NUM_BANKS-1:0][ddr4_cmd_pkg::ROW_BITS-1:0] open_rows,
    output logic                                                    pop,
    output logic                                                    issue_valid,
    output ddr4_cmd_pkg::dram_sel_t                                 issued
);
    import ddr4_cmd_pkg::*;

    // Widest latency sets the wait counter size
    localparam int MAX_PA = (PRECHARGE_LATENCY > ACTIVATION_LATENCY) ?
                            PRECHARGE_LATENCY : ACTIVATION_LATENCY;
    localparam int MAX_CR = (ACCESS_LATENCY > REFRESH_LATENCY) ?
                            ACCESS_LATENCY : REFRESH_LATENCY;
    localparam int WAIT_MAX = (MAX_PA > MAX_CR) ? MAX_PA : MAX_CR;
    localparam int WAIT_BITS = $clog2(WAIT_MAX + 1);
    localparam int REF_BITS = $clog2(REFRESH_INTERVAL + 1);

    typedef enum logic [1:0] {
        IDLE,          // Free to issue
        WAIT,          // Spacing after a request command or REFRESH
        REFRESH_PEND   // Banks closing, REFRESH goes out when the count ends
    } sched_state_e;

    sched_state_e          state;
    logic [WAIT_BITS-1:0]  wait_cnt;  // Cycles left of the last command's latency
    logic [REF_BITS-1:0]   ref_cnt;
    logic                  ref_pend;  // Refresh tick not yet served
    logic                  mid_req;   // Head request has PRE or ACT out already
    logic                  can_go;
    logic                  ref_go;
    logic [BG_BITS+BA_BITS-1:0] head_bank;
    logic                  head_hit;

    assign head_bank = {head.bg, head.ba};
    assign head_hit = open_banks[head_bank] && (open_rows[head_bank] == head.row);

    // Last cycle of a wait may already carry the next command
    assign can_go = (state == IDLE) || (state == WAIT && wait_cnt == '0);
    assign ref_go = (state == REFRESH_PEND) && (wait_cnt == '0);

    // Next command choice
    always_comb begin
        issued = '{cmd: NOP, bg: '0, ba: '0, row: '0, col: '0};
        issue_valid = 1'b0;
        pop = 1'b0;
        if (ref_go) begin
            issued.cmd = REFRESH;
            issue_valid = 1'b1;
        end else if (can_go && ref_pend && !mid_req) begin
            // Refresh wins at a request boundary
            issued.cmd = (|open_banks) ? PRECHARGE_ALL : REFRESH;
            issue_valid = 1'b1;
        end else if (can_go && head_valid) begin
            issued.bg = head.bg;
            issued.ba = head.ba;
            issued.row = head.row;
            issued.col = head.col;
            issue_valid = 1'b1;
            if (!open_banks[head_bank]) begin
                issued.cmd = ACTIVATE;     // Closed bank
            end else if (!head_hit) begin
                issued.cmd = PRECHARGE;    // Row conflict
            end else begin
                issued.cmd = head.write ? WRITE : READ;
                pop = 1'b1;                // Last command of the request
            end
        end
    end

    // Latency tracking
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            state <= IDLE;
            wait_cnt <= '0;
            mid_req <= 1'b0;
        end else if (issue_valid) begin
            state <= WAIT;
            mid_req <= (issued.cmd == ACTIVATE) || (issued.cmd == PRECHARGE);
            case (issued.cmd)
                ACTIVATE: wait_cnt <= WAIT_BITS'(ACTIVATION_LATENCY - 1);
                PRECHARGE: wait_cnt <= WAIT_BITS'(PRECHARGE_LATENCY - 1);
                PRECHARGE_ALL: begin
                    state <= REFRESH_PEND;
                    wait_cnt <= WAIT_BITS'(PRECHARGE_LATENCY - 1);
                end
                REFRESH: wait_cnt <= WAIT_BITS'(REFRESH_LATENCY - 1);
                default: wait_cnt <= WAIT_BITS'(ACCESS_LATENCY - 1);  // READ or WRITE
            endcase
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end else if (state == WAIT) begin
            state <= IDLE;  // Nothing was ready when the wait ended
        end
    end

    // Refresh interval, paused while a tick is waiting to be served
    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            ref_cnt <= '0;
            ref_pend <= 1'b0;
        end else if (ref_pend) begin
            if (issue_valid && issued.cmd == REFRESH) begin
                ref_pend <= 1'b0;
            end
        end else if (ref_cnt == REF_BITS'(REFRESH_INTERVAL - 1)) begin
            ref_cnt <= '0;
            ref_pend <= 1'b1;
        end else begin
            ref_cnt <= ref_cnt + 1'b1;
        end
    end

endmodule : ddr4_cmd_scheduler

// ==== design/ddr4_cmd_encoder.sv ====
`timescale 1ns/1ps

module ddr4_cmd_encoder (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     issue_valid,
    input  ddr4_cmd_pkg::dram_sel_t  issued,
    output ddr4_cmd_pkg::dram_pins_t dram_cmd
);
    import ddr4_cmd_pkg::*;

    // Deselect, every strobe high
    localparam dram_pins_t PINS_NOP = '{
        cs_n: 1'b1, act_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
        bg: '0, ba: '0, addr: '0
    };

    dram_pins_t pins_d;

    // DDR4 command truth table
    always_comb begin
        pins_d = PINS_NOP;
        if (issue_valid && issued.cmd != NOP) begin
            pins_d.cs_n = 1'b0;
            pins_d.bg = issued.bg;
            pins_d.ba = issued.ba;
            case (issued.cmd)
                ACTIVATE: begin
                    pins_d.act_n = 1'b0;
                    pins_d.addr = {{(DRAM_ADDR_BITS-ROW_BITS){1'b0}}, issued.row};
                    // RAS/CAS/WE carry row bits A16..A14 here
                    pins_d.ras_n = pins_d.addr[16];
                    pins_d.cas_n = pins_d.addr[15];
                    pins_d.we_n = pins_d.addr[14];
                end
                READ, WRITE: begin
                    pins_d.cas_n = 1'b0;
                    pins_d.we_n = (issued.cmd == READ);  // Low for a write
                    pins_d.addr = {{(DRAM_ADDR_BITS-COL_BITS){1'b0}}, issued.col};
                end
                PRECHARGE: begin
                    pins_d.ras_n = 1'b0;
                    pins_d.we_n = 1'b0;  // A10 stays low, one bank
                end
                PRECHARGE_ALL: begin
                    pins_d.ras_n = 1'b0;
                    pins_d.we_n = 1'b0;
                    pins_d.bg = '0;
                    pins_d.ba = '0;
                    pins_d.addr[10] = 1'b1;  // A10 high selects all banks
                end
                default: begin  // REFRESH
                    pins_d.ras_n = 1'b0;
                    pins_d.cas_n = 1'b0;
                    pins_d.bg = '0;
                    pins_d.ba = '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            dram_cmd <= PINS_NOP;
        end else begin
            dram_cmd <= pins_d;
        end
    end

endmodule : ddr4_cmd_encoder

// ==== design/ddr4_cmd_ctrl.sv ====
`timescale 1ns/1ps

module ddr4_cmd_ctrl #(
    parameter int QUEUE_DEPTH        = 8,
    parameter int PRECHARGE_LATENCY  = 5,
    parameter int ACTIVATION_LATENCY = 8,
    parameter int ACCESS_LATENCY     = 4,
    parameter int REFRESH_LATENCY    = 12,
    parameter int REFRESH_INTERVAL   = 200
) (
    input  logic                                    clk_in,
    input  logic                                    rst_in,
    input  logic                                    req_valid,
    input  logic                                    req_write,
    input  logic [ddr4_cmd_pkg::HOST_ADDR_BITS-1:0] req_addr,
    output logic                                    req_ready,
    output ddr4_cmd_pkg::dram_pins_t                dram_cmd
);
    import ddr4_cmd_pkg::*;

    dram_req_t head;        // Oldest queued request
    logic      head_valid;
    logic      pop;
    dram_sel_t issued;      // Command chosen this cycle
    logic      issue_valid;
    logic [NUM_BANKS-1:0]               open_banks;
    logic [NUM_BANKS-1:0][ROW_BITS-1:0] open_rows;

    ddr4_req_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_queue (
        .clk_in    (clk_in),
        .rst_in    (rst_in),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .pop       (pop),
        .req_ready (req_ready),
        .head_valid(head_valid),
        .head      (head)
    );

    ddr4_bank_tracker u_banks (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .issue_valid(issue_valid),
        .issued     (issued),
        .open_banks (open_banks),
        .open_rows  (open_rows)
    );

    ddr4_cmd_scheduler #(
        .PRECHARGE_LATENCY (PRECHARGE_LATENCY),
        .ACTIVATION_LATENCY(ACTIVATION_LATENCY),
        .ACCESS_LATENCY    (ACCESS_LATENCY),
        .REFRESH_LATENCY   (REFRESH_LATENCY),
        .REFRESH_INTERVAL  (REFRESH_INTERVAL)
    ) u_sched (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .head_valid (head_valid),
        .head       (head),
        .open_banks (open_banks),
        .open_rows  (open_rows),
        .pop        (pop),
        .issue_valid(issue_valid),
        .issued     (issued)
    );

    // Pins lag the choice by one cycle
    ddr4_cmd_encoder u_enc (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .issue_valid(issue_valid),
        .issued     (issued),
        .dram_cmd   (dram_cmd)
    );

endmodule : ddr4_cmd_ctrl

// ==== dv/ddr4_cmd_ctrl_assertions.sv ====
`timescale 1ns/1ps

module ddr4_cmd_ctrl_assertions #(
    parameter int PRECHARGE_LATENCY  = 5,
    parameter int ACTIVATION_LATENCY = 8
) (
    input logic                     clk_in,
    input logic                     rst_in,
    input logic                     req_ready,
    input ddr4_cmd_pkg::dram_pins_t dram_cmd
);
    int   fail_cnt = 0;  // Failed assertions so far
    logic is_act;
    logic is_rw;
    logic is_pre;        // PRECHARGE or PRECHARGE_ALL
    logic is_ref;

    assign is_act = !dram_cmd.cs_n && !dram_cmd.act_n;
    assign is_rw = !dram_cmd.cs_n && dram_cmd.act_n && dram_cmd.ras_n && !dram_cmd.cas_n;
    assign is_pre = !dram_cmd.cs_n && dram_cmd.act_n && !dram_cmd.ras_n
                    && dram_cmd.cas_n && !dram_cmd.we_n;
    assign is_ref = !dram_cmd.cs_n && dram_cmd.act_n && !dram_cmd.ras_n
                    && !dram_cmd.cas_n && dram_cmd.we_n;

    reset_deselect: assert property (@(posedge clk_in) rst_in |-> dram_cmd.cs_n) else begin
        fail_cnt++;
        $error("cs_n low during reset");
    end

    // tRCD
    act_to_access: assert property (@(posedge clk_in) disable iff (rst_in)
        is_act |=> !is_rw [* ACTIVATION_LATENCY-1]) else begin
        fail_cnt++;
        $error("READ or WRITE closer than tRCD to ACTIVATE");
    end

    // tRP
    pre_to_act: assert property (@(posedge clk_in) disable iff (rst_in)
        is_pre |=> !(is_act || is_ref) [* PRECHARGE_LATENCY-1]) else begin
        fail_cnt++;
        $error("ACTIVATE or REFRESH closer than tRP to a precharge");
    end

    ready_after_reset: assert property (@(posedge clk_in) $fell(rst_in) |-> req_ready) else begin
        fail_cnt++;
        $error("req_ready low after reset");
    end

endmodule : ddr4_cmd_ctrl_assertions

bind ddr4_cmd_ctrl ddr4_cmd_ctrl_assertions #(
    .PRECHARGE_LATENCY (PRECHARGE_LATENCY),
    .ACTIVATION_LATENCY(ACTIVATION_LATENCY)
) u_assert (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .req_ready(req_ready),
    .dram_cmd (dram_cmd)
);

// ==== dv/ddr4_cmd_ctrl_tb.sv ====
`timescale 1ns/1ps

module ddr4_cmd_ctrl_tb;
    import ddr4_cmd_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_REQS = 300;
    localparam int QUEUE_DEPTH = 8;
    localparam int REFRESH_INTERVAL = 200;
    // Worst request is PRE + ACT + access plus one PREA + REF and the longest idle gap
    localparam int WORST_CYCLES = 5 + 8 + 4 + 5 + 12 + 4;
    localparam int WATCHDOG_CYCLES = NUM_REQS * WORST_CYCLES + 1000;

    logic                      clk_in;
    logic                      rst_in;
    logic                      req_valid;
    logic                      req_write;
    logic [HOST_ADDR_BITS-1:0] req_addr;
    logic                      req_ready;
    dram_pins_t                dram_cmd;

    integer seed;
    int errors = 0;
    int accepted = 0;
    int accesses = 0;
    int stalls = 0;             // Cycles the host was held off by a full queue
    int cycle = 0;
    int last_ref = -1;          // Cycle of the previous REFRESH
    logic mid_req = 1'b0;       // PRE or ACT of the head request already out
    logic prea_seen = 1'b0;     // PRECHARGE_ALL still waiting for its REFRESH
    logic [NUM_BANKS-1:0] open_m = '0;
    logic [ROW_BITS-1:0]  row_m [NUM_BANKS];
    dram_req_t exp_q [$];       // Accepted requests still missing their access

    ddr4_cmd_ctrl #(
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .REFRESH_INTERVAL(REFRESH_INTERVAL)
    ) dut0 (.*);

    task automatic compare_field(input string name, input int exp, input int act);
        assert (exp == act) else begin
            errors++;
            $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
        end
    endtask

    task automatic require(input logic ok, input string what);
        assert (ok) else begin
            errors++;
            $display("Failure at %0t ns: %s", $time, what);
        end
    endtask

    // Flat host address holds column, bank, bank group and row from the bottom up
    function automatic dram_req_t split_addr(input logic wr,
                                             input logic [HOST_ADDR_BITS-1:0] a);
        dram_req_t r;
        r.write = wr;
        r.col = a[COL_BITS-1:0];
        r.ba = a[COL_BITS +: BA_BITS];
        r.bg = a[COL_BITS+BA_BITS +: BG_BITS];
        r.row = a[HOST_ADDR_BITS-1 -: ROW_BITS];
        return r;
    endfunction

    // Decode the pins and step the bank model
    task automatic check_command();
        dram_req_t h;
        logic [BG_BITS+BA_BITS-1:0] bank;
        logic [2:0] strobes;        // RAS_n, CAS_n, WE_n
        strobes = {dram_cmd.ras_n, dram_cmd.cas_n, dram_cmd.we_n};
        bank = {dram_cmd.bg, dram_cmd.ba};
        h = '0;
        if (exp_q.size() > 0) h = exp_q[0];
        require(!prea_seen || (dram_cmd.act_n && strobes == 3'b001),
            "PRECHARGE_ALL not followed by REFRESH");
        if (!dram_cmd.act_n) begin  // ACTIVATE
            require(exp_q.size() > 0 && !open_m[bank],
                "ACTIVATE without a request to a closed bank");
            compare_field("dram_cmd.{bg,ba}", {h.bg, h.ba}, bank);
            compare_field("dram_cmd.addr", h.row, dram_cmd.addr);
            compare_field("dram_cmd.{ras_n,cas_n,we_n}", 0, strobes);  // Row bits A16..A14
            open_m[bank] = 1'b1;
            row_m[bank] = dram_cmd.addr[ROW_BITS-1:0];
            mid_req = 1'b1;
        end else if (strobes == 3'b101 || strobes == 3'b100) begin  // READ or WRITE
            require(exp_q.size() > 0 && open_m[bank] && row_m[bank] == h.row,
                "access issued without its row open");
            compare_field("dram_cmd.{bg,ba}", {h.bg, h.ba}, bank);
            compare_field("dram_cmd.addr", h.col, dram_cmd.addr);
            compare_field("dram_cmd.we_n", !h.write, dram_cmd.we_n);
            if (exp_q.size() > 0) void'(exp_q.pop_front());
            accesses++;
            mid_req = 1'b0;
        end else if (strobes == 3'b010 && !dram_cmd.addr[10]) begin  // PRECHARGE
            require(exp_q.size() > 0 && open_m[bank] && row_m[bank] != h.row,
                "PRECHARGE without a row conflict");
            compare_field("dram_cmd.{bg,ba}", {h.bg, h.ba}, bank);
            compare_field("dram_cmd.addr", 0, dram_cmd.addr);
            open_m[bank] = 1'b0;
            mid_req = 1'b1;
        end else if (strobes == 3'b010) begin  // PRECHARGE_ALL
            require(open_m != '0 && !mid_req,
                "PRECHARGE_ALL with no bank open or inside a request");
            compare_field("dram_cmd.addr", 1 << 10, dram_cmd.addr);
            open_m = '0;
            prea_seen = 1'b1;
        end else if (strobes == 3'b001) begin  // REFRESH
            require(open_m == '0 && !mid_req, "REFRESH with a bank open or inside a request");
            require(last_ref < 0 || cycle - last_ref >= REFRESH_INTERVAL,
                "REFRESH came sooner than the refresh interval");
            last_ref = cycle;
            prea_seen = 1'b0;
        end else begin
            require(1'b0, "unknown command on the DDR4 pins");
        end
    endtask

    // Drive one request from a few busy rows and hold it until taken
    task automatic send_request(input int gap);
        logic [31:0] r;
        logic [ROW_BITS-1:0] row;
        logic taken;
        r = $random(seed);
        row = (r[2:0] == 3'd0) ? r[31:24] : {r[4:3], 6'h15};
        req_addr = {row, r[6:5], r[13], r[7], r[11:8]};  // Row, bg, ba, col
        req_write = r[12];
        req_valid = 1'b1;
        do begin
            @(negedge clk_in);
            taken = req_ready;  // Same value the next edge sees
            @(posedge clk_in);
            #10;
        end while (!taken);
        req_valid = 1'b0;
        repeat (gap) begin
            @(posedge clk_in);
            #10;
        end
    endtask

    initial begin
        clk_in = 1'b0;
        forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
    end

    // Monitor samples mid-cycle where all signals are stable
    always @(negedge clk_in) begin
        if (!rst_in) begin
            cycle++;
            if (!dram_cmd.cs_n) check_command();
            // Queue holds every accepted request until its access shows on the pins
            compare_field("req_ready", exp_q.size() < QUEUE_DEPTH, req_ready);
            if (req_valid && req_ready) begin
                exp_q.push_back(split_addr(req_write, req_addr));
                accepted++;
            end
            if (req_valid && !req_ready) stalls++;
        end
    end

    initial begin
        int gap;
        seed = 32'h43b7;
        rst_in = 1'b1;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        repeat (4) @(posedge clk_in);
        #10;
        rst_in = 1'b0;
        for (int i = 0; i < NUM_REQS; i++) begin
            // Requests 100 to 159 go back to back to fill the queue
            gap = (i >= 100 && i < 160) ? 0 : $unsigned($random(seed)) % 4;
            send_request(gap);
        end
        while (exp_q.size() != 0) @(posedge clk_in);
        repeat (20) @(posedge clk_in);  // Catch stray commands after the drain
        require(stalls > 0, "queue never filled during the back-to-back burst");
        require(accepted == NUM_REQS && accesses == accepted,
            "accepted and served counts differ");
        errors += dut0.u_assert.fail_cnt;
        $display("Accepted %0d, accesses %0d, errors %0d, assertion failures %0d",
            accepted, accesses, errors, dut0.u_assert.fail_cnt);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: run still busy after %0d cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule : ddr4_cmd_ctrl_tb

// ==== ddr4_cmd_ctrl.f ====
design/ddr4_cmd_pkg.sv
design/ddr4_req_queue.sv
design/ddr4_bank_tracker.sv
design/ddr4_cmd_scheduler.sv
design/ddr4_cmd_encoder.sv
design/ddr4_cmd_ctrl.sv
dv/ddr4_cmd_ctrl_assertions.sv
dv/ddr4_cmd_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: ddr4_cmd_ctrl

sources:
  - files:
      - design/ddr4_cmd_pkg.sv
      - design/ddr4_req_queue.sv
      - design/ddr4_bank_tracker.sv
      - design/ddr4_cmd_scheduler.sv
      - design/ddr4_cmd_encoder.sv
      - design/ddr4_cmd_ctrl.sv
  - target: simulation
    files:
      - dv/ddr4_cmd_ctrl_assertions.sv
      - dv/ddr4_cmd_ctrl_tb.sv
